// File: d_cache_top.f
+incdir+design
design/d_cache_pkg.sv
design/cache_tag_array.sv
design/cache_data_array.sv
design/far_mem.sv
design/cache_ctrl.sv
design/d_cache_top.sv
sim/d_cache_props.sv
sim/d_cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the data cache testbench with Verilator and run it.
# The exit status is nonzero when the build or the simulation fails.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module d_cache_tb \
    -f d_cache_top.f -o d_cache_sim \
    && ./obj_dir/d_cache_sim \
    || exit 1

// File: sim/d_cache_tb.sv
//======================================================================
// Directed testbench for the data cache, with a scoreboard copy of memory.
// Drives the core port 1 ns after each rising edge, stops at first error.
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module d_cache_tb;

    localparam int READY_LIMIT = 8;  // Cycles allowed with ready low
    localparam int RSP_LIMIT   = 8;  // Cycles allowed from accept to response

    logic                   clk;
    logic                   rst_n;
    d_cache_pkg::t_req      req;
    logic                   ready;
    d_cache_pkg::t_rd_rsp   rsp;
    logic [31:0]            sb_mem [0:16383];  // Expected word per word address
    logic [31:0]            rng;

    d_cache_top d_cache_top_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .core2cache_req (req),
        .ready          (ready),
        .cache2core_rsp (rsp)
    );

    always #5 clk = ~clk;  // 10 ns period

    //==================================================================
    // Helpers
    //==================================================================
    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else
            stop_on_failure($sformatf("ERROR: time %0t %s got %h expected %h",
                                      $time, name, got, exp));
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // Holds the request until the edge where ready is high
    task automatic accept_request();
        int cycles;
        cycles = 0;
        while (!ready) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > READY_LIMIT) stop_on_failure("ready stayed low too long");
        end
        @(posedge clk);  // Accepting edge
        #1;
        req.valid = 1'b0;
    endtask

    task automatic send_write(input logic [15:0] addr, input logic [31:0] data);
        req = '{valid: 1'b1, opcode: d_cache_pkg::WR_OP, address: addr,
                data: data, reg_id: 5'd0};
        accept_request();
        sb_mem[addr[15:2]] = data;  // Far memory takes it at the accept edge
    endtask

    // lat counts cycles past the first one, so a hit gives zero
    task automatic send_read_check(input logic [15:0] addr, input logic [4:0] reg_id,
                                   output int lat);
        req = '{valid: 1'b1, opcode: d_cache_pkg::RD_OP, address: addr,
                data: 32'd0, reg_id: reg_id};
        accept_request();
        lat = 0;
        while (!rsp.valid) begin
            @(posedge clk);
            #1;
            lat++;
            if (lat > RSP_LIMIT) stop_on_failure("no read response arrived in time");
        end
        check_value("cache2core_rsp.data", rsp.data, sb_mem[addr[15:2]]);
        check_value("cache2core_rsp.address", 32'(rsp.address), 32'(addr));
        check_value("cache2core_rsp.reg_id", 32'(rsp.reg_id), 32'(reg_id));
    endtask

    //==================================================================
    // Directed tests
    //==================================================================
    task automatic test_reset_read();
        int lat;
        assert (ready) else stop_on_failure("ready is low after reset");
        send_read_check(16'h0a34, 5'd1, lat);  // Never written, reads zero
    endtask

    task automatic test_write_read();
        int lat;
        send_write(16'h1238, 32'hcafe_f00d);
        send_read_check(16'h1238, 5'd7, lat);
    endtask

    task automatic test_back_to_back();
        int lat;
        send_write(16'h4450, 32'h0a0b_0c0d);   // Write misses, far memory only
        send_write(16'h4454, 32'h1a1b_1c1d);
        send_read_check(16'h4450, 5'd3, lat);  // Miss, fills the line
        send_read_check(16'h4454, 5'd4, lat);  // Same line, now a hit
        check_value("hit response latency", 32'(lat), 32'd0);
    endtask

    task automatic test_write_neighbors();
        int lat;
        send_write(16'h4450, 32'h1111_0000);
        send_write(16'h4458, 32'h3333_0000);
        send_read_check(16'h4458, 5'd5, lat);  // Line now cached
        send_write(16'h4458, 32'h3333_beef);   // Write hit updates the array
        send_read_check(16'h4458, 5'd6, lat);
        send_read_check(16'h4450, 5'd8, lat);
        send_read_check(16'h4454, 5'd9, lat);
        send_read_check(16'h445c, 5'd10, lat);
    endtask

    task automatic test_eviction();
        int lat;
        send_write(16'h2040, 32'haaaa_2040);  // Set 4, tag 0x20
        send_write(16'h5040, 32'h5555_5040);  // Set 4, tag 0x50
        repeat (3) begin
            send_read_check(16'h2040, 5'd11, lat);
            send_read_check(16'h5040, 5'd12, lat);
        end
    endtask

    task automatic test_random();
        logic [5:0]     w;
        logic [15:0]    addr;
        int             lat;
        repeat (200) begin
            rng = xorshift(rng);
            w   = rng[5:0];
            // Four tags over four sets, so lines keep evicting each other
            addr = {6'h0c, w[5:4], 2'b00, w[3:2], w[1:0], 2'b00};
            if (rng[8]) begin
                send_write(addr, xorshift(rng ^ 32'h9e37_79b9));
            end else begin
                send_read_check(addr, rng[13:9], lat);
            end
        end
    endtask

    //==================================================================
    // Main sequence
    //==================================================================
    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        req   = '0;
        rng   = 32'h2bece302;
        foreach (sb_mem[i]) sb_mem[i] = '0;  // Far memory resets to zero
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset_read();
        test_write_read();
        test_back_to_back();
        test_write_neighbors();
        test_eviction();
        test_random();
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/d_cache_props.sv
//======================================================================
// Concurrent checks on the cache's core port, bound to the top level.
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module d_cache_props (
    input logic                     clk,
    input logic                     rst_n,
    input var d_cache_pkg::t_req    core2cache_req,
    input logic                     ready,
    input var d_cache_pkg::t_rd_rsp cache2core_rsp
);

    logic acc_wr;

    assign acc_wr = core2cache_req.valid && ready &&
                    (core2cache_req.opcode == d_cache_pkg::WR_OP);

    // Writes never produce a response
    no_rsp_after_write: assert property (@(posedge clk) disable iff (!rst_n)
        acc_wr |=> !cache2core_rsp.valid)
        else $error("read response after an accepted write");

    // A miss keeps ready low for two cycles
    ready_low_bounded: assert property (@(posedge clk) disable iff (!rst_n)
        (!ready && !$past(ready, 1) && !$past(ready, 2) && !$past(ready, 3)) |=> ready)
        else $error("ready low for more than four cycles");

    rsp_idle_in_reset: assert property (@(posedge clk) !rst_n |-> !cache2core_rsp.valid)
        else $error("response valid during reset");

    // First active edge after release must not raise a response
    rsp_idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |=> !cache2core_rsp.valid)
        else $error("response valid in first cycle after reset");

endmodule

bind d_cache_top d_cache_props d_cache_props_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .core2cache_req (core2cache_req),
    .ready          (ready),
    .cache2core_rsp (cache2core_rsp)
);

`default_nettype wire

// File: design/d_cache_top.sv
//======================================================================
// Data cache top level: controller, tag and data arrays, far memory.
// The core connects here through the request, ready and response ports.
//======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "d_cache_macros.svh"

module d_cache_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  var d_cache_pkg::t_req   core2cache_req,
    output logic                    ready,
    output d_cache_pkg::t_rd_rsp    cache2core_rsp
);

    //==================================================================
    // Internal wiring
    //==================================================================
    logic                               hit;
    logic                               tag_fill;
    logic                               data_wr;
    logic                               data_fill;
    d_cache_pkg::t_cl                   fill_line;
    logic [`D_CACHE_DATA_W-1:0]         rd_word;
    logic [`D_CACHE_SET_W-1:0]          set;
    logic [`D_CACHE_TAG_W-1:0]          tag;
    logic [$clog2(`D_CACHE_WORDS)-1:0]  word_offset;
    d_cache_pkg::t_mem_req              mem_req;
    d_cache_pkg::t_mem_rsp              mem_rsp;

    cache_ctrl cache_ctrl_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .core2cache_req (core2cache_req),
        .ready          (ready),
        .cache2core_rsp (cache2core_rsp),
        .hit            (hit),
        .tag_fill       (tag_fill),
        .data_wr        (data_wr),
        .data_fill      (data_fill),
        .fill_line      (fill_line),
        .rd_word        (rd_word),
        .set            (set),
        .tag            (tag),
        .word_offset    (word_offset),
        .mem_req        (mem_req),
        .mem_rsp        (mem_rsp)
    );

    cache_tag_array cache_tag_array_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .set     (set),
        .tag     (tag),
        .fill_en (tag_fill),
        .hit     (hit)
    );

    // Write data comes straight from the core request
    cache_data_array cache_data_array_inst (
        .clk         (clk),
        .set         (set),
        .word_offset (word_offset),
        .wr_en       (data_wr),
        .wr_data     (core2cache_req.data),
        .fill_en     (data_fill),
        .fill_line   (fill_line),
        .rd_word     (rd_word)
    );

    far_mem far_mem_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

endmodule

`default_nettype wire

// File: design/cache_ctrl.sv
//======================================================================
// Cache controller: lookup and miss FSM, write-through forwarding to
// far memory and the registered read response to the core.
//======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "d_cache_macros.svh"

module cache_ctrl (
    input  logic                                clk,
    input  logic                                rst_n,
    // Core port
    input  var d_cache_pkg::t_req               core2cache_req,
    output logic                                ready,
    output d_cache_pkg::t_rd_rsp                cache2core_rsp,
    // Tag and data arrays
    input  logic                                hit,
    output logic                                tag_fill,
    output logic                                data_wr,
    output logic                                data_fill,
    output d_cache_pkg::t_cl                    fill_line,
    input  logic [`D_CACHE_DATA_W-1:0]          rd_word,
    output logic [`D_CACHE_SET_W-1:0]           set,
    output logic [`D_CACHE_TAG_W-1:0]           tag,
    output logic [$clog2(`D_CACHE_WORDS)-1:0]   word_offset,
    // Far memory
    output d_cache_pkg::t_mem_req               mem_req,
    input  var d_cache_pkg::t_mem_rsp           mem_rsp
);

    typedef enum logic [1:0] {
        ST_LOOKUP,    // Accepting requests
        ST_MISS_REQ,  // Line read goes out
        ST_MISS_WAIT  // Waiting on far memory line
    } t_state;

    t_state                         state;
    t_state                         next_state;
    logic                           acc_rd;
    logic                           acc_wr;
    logic                           line_back;    // Missed line arriving this cycle
    logic [`D_CACHE_ADDR_W-1:0]     addr_sel;     // Live or captured address
    logic [`D_CACHE_ADDR_W-1:0]     cap_address;
    logic [`D_CACHE_REG_ID_W-1:0]   cap_reg_id;
    logic                           rsp_valid;
    logic [`D_CACHE_ADDR_W-1:0]     rsp_address;
    logic [`D_CACHE_REG_ID_W-1:0]   rsp_reg_id;
    logic [`D_CACHE_DATA_W-1:0]     rsp_data;

    //==================================================================
    // Accept and index steering
    //==================================================================
    assign ready     = (state == ST_LOOKUP);
    assign acc_rd    = core2cache_req.valid && ready && (core2cache_req.opcode == d_cache_pkg::RD_OP);
    assign acc_wr    = core2cache_req.valid && ready && (core2cache_req.opcode == d_cache_pkg::WR_OP);
    assign line_back = (state == ST_MISS_WAIT) && mem_rsp.valid;

    assign addr_sel    = ready ? core2cache_req.address : cap_address;
    assign set         = addr_sel[`D_CACHE_MSB_SET:`D_CACHE_LSB_SET];
    assign tag         = addr_sel[`D_CACHE_MSB_TAG:`D_CACHE_LSB_TAG];
    assign word_offset = addr_sel[`D_CACHE_MSB_WORD_OFFSET:`D_CACHE_LSB_WORD_OFFSET];

    // Write-through, cached copy only touched on a hit
    assign data_wr   = acc_wr && hit;
    assign tag_fill  = line_back;
    assign data_fill = line_back;
    assign fill_line = mem_rsp.line;

    //==================================================================
    // Far memory request
    //==================================================================
    assign mem_req.valid       = acc_wr || (state == ST_MISS_REQ);
    assign mem_req.write       = acc_wr;
    assign mem_req.cl_address  = addr_sel[`D_CACHE_MSB_TAG:`D_CACHE_LSB_SET];
    assign mem_req.word_offset = word_offset;
    assign mem_req.data        = core2cache_req.data;  // Don't care on line reads

    //==================================================================
    // FSM
    //==================================================================
    always_comb begin
        next_state = state;
        case (state)
            ST_LOOKUP:    if (acc_rd && !hit) next_state = ST_MISS_REQ;
            ST_MISS_REQ:  next_state = ST_MISS_WAIT;
            ST_MISS_WAIT: if (mem_rsp.valid) next_state = ST_LOOKUP;
            default:      next_state = ST_LOOKUP;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_LOOKUP;
        end else begin
            state <= next_state;
        end
    end

    // Missed request held until its line returns
    always_ff @(posedge clk) begin
        if (acc_rd && !hit) begin
            cap_address <= core2cache_req.address;
            cap_reg_id  <= core2cache_req.reg_id;
        end
    end

    //==================================================================
    // Read response
    //==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= (acc_rd && hit) || line_back;  // One pulse per read
        end
    end

    always_ff @(posedge clk) begin
        if (acc_rd && hit) begin
            rsp_address <= core2cache_req.address;
            rsp_reg_id  <= core2cache_req.reg_id;
            rsp_data    <= rd_word;                      // From data array
        end else if (line_back) begin
            rsp_address <= cap_address;
            rsp_reg_id  <= cap_reg_id;
            rsp_data    <= mem_rsp.line.word[word_offset]; // Bypass the fill
        end
    end

    assign cache2core_rsp.valid   = rsp_valid;
    assign cache2core_rsp.address = rsp_address;
    assign cache2core_rsp.reg_id  = rsp_reg_id;
    assign cache2core_rsp.data    = rsp_data;

endmodule

`default_nettype wire

// File: design/far_mem.sv
//======================================================================
// Flat backing memory behind the cache, one line per address.
// Word writes land at the request edge, line reads answer a cycle later.
//======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "d_cache_macros.svh"

module far_mem (
    input  logic                        clk,
    input  logic                        rst_n,
    input  var d_cache_pkg::t_mem_req   mem_req,
    output d_cache_pkg::t_mem_rsp       mem_rsp
);

    localparam int NUM_LINES = 2**`D_CACHE_CL_ADRS_W;  // 4096 lines

    d_cache_pkg::t_cl   mem [NUM_LINES];
    d_cache_pkg::t_cl   next_line;     // Addressed line after the merge
    logic               wr_en;
    logic               rd_en;
    logic               rsp_valid;
    d_cache_pkg::t_cl   rsp_line;

    assign wr_en = mem_req.valid && mem_req.write;
    assign rd_en = mem_req.valid && !mem_req.write;

    //==================================================================
    // Write path
    //==================================================================
    always_comb begin
        next_line = mem[mem_req.cl_address];
        next_line.word[mem_req.word_offset] = mem_req.data;  // Overlay one word
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem <= '{default: '0};                     // Memory starts all zero
        end else if (wr_en) begin
            mem[mem_req.cl_address] <= next_line;
        end
    end

    //==================================================================
    // Read path
    //==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= rd_en;  // Single-cycle pulse per read
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rsp_line <= mem[mem_req.cl_address];
        end
    end

    assign mem_rsp.valid = rsp_valid;
    assign mem_rsp.line  = rsp_line;

endmodule

`default_nettype wire

// File: design/cache_data_array.sv
//======================================================================
// Line storage for the cache: word merges, whole-line fills and
// a combinational word read for the addressed set.
//======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "d_cache_macros.svh"

module cache_data_array (
    input  logic                                clk,
    input  logic [`D_CACHE_SET_W-1:0]           set,
    input  logic [$clog2(`D_CACHE_WORDS)-1:0]   word_offset,
    input  logic                                wr_en,      // Write-through hit
    input  logic [`D_CACHE_DATA_W-1:0]          wr_data,
    input  logic                                fill_en,    // Refill from far memory
    input  var d_cache_pkg::t_cl                fill_line,
    output logic [`D_CACHE_DATA_W-1:0]          rd_word
);

    localparam int NUM_SETS = 2**`D_CACHE_SET_W;

    d_cache_pkg::t_cl lines [NUM_SETS];

    //==================================================================
    // Write side
    //==================================================================
    // Fill and word write never coincide, fill only happens in a miss
    always_ff @(posedge clk) begin
        if (fill_en) begin
            lines[set].raw <= fill_line.raw;               // Flat line copy
        end else if (wr_en) begin
            lines[set].word[word_offset] <= wr_data;       // Single word merge
        end
    end

    //==================================================================
    // Read side
    //==================================================================
    // Word view picks the requested 32 bits
    assign rd_word = lines[set].word[word_offset];

endmodule

`default_nettype wire

// File: design/cache_tag_array.sv
//======================================================================
// Tag and valid storage per set, with the combinational hit compare.
// Filled by the controller when a missed line comes back.
//======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "d_cache_macros.svh"

module cache_tag_array (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`D_CACHE_SET_W-1:0]   set,      // Index from controller
    input  logic [`D_CACHE_TAG_W-1:0]   tag,      // Tag to compare or store
    input  logic                        fill_en,
    output logic                        hit
);

    localparam int NUM_SETS = 2**`D_CACHE_SET_W;

    logic [`D_CACHE_TAG_W-1:0]  tags [NUM_SETS];
    logic [NUM_SETS-1:0]        valid_q;  // One bit per set

    //==================================================================
    // Valid bits
    //==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;  // Whole cache empty
        end else if (fill_en) begin
            valid_q[set] <= 1'b1;
        end
    end

    //==================================================================
    // Tag storage
    //==================================================================
    always_ff @(posedge clk) begin
        if (fill_en) begin
            tags[set] <= tag;  // New owner of the set
        end
    end

    // Direct-mapped lookup, one compare
    assign hit = valid_q[set] && (tags[set] == tag);

endmodule

`default_nettype wire

// File: design/d_cache_pkg.sv
//======================================================================
// Shared types for the data cache, far memory and core port.
// Referenced by scoped name from each block.
//======================================================================
`default_nettype none

`include "d_cache_macros.svh"

package d_cache_pkg;

    //==================================================================
    // Core side
    //==================================================================
    typedef enum logic {
        RD_OP = 1'b0,
        WR_OP = 1'b1
    } t_opcode;

    // Load/store request from the core, 55 bits
    typedef struct packed {
        logic                           valid;
        t_opcode                        opcode;
        logic [`D_CACHE_ADDR_W-1:0]     address;  // Byte address
        logic [`D_CACHE_DATA_W-1:0]     data;     // Write data, ignored on reads
        logic [`D_CACHE_REG_ID_W-1:0]   reg_id;
    } t_req;

    // Read response back to the core, 54 bits
    typedef struct packed {
        logic                           valid;
        logic [`D_CACHE_ADDR_W-1:0]     address;  // Echo of request
        logic [`D_CACHE_REG_ID_W-1:0]   reg_id;   // Echo of request
        logic [`D_CACHE_DATA_W-1:0]     data;
    } t_rd_rsp;

    // One line, seen flat by the fill path or word by word
    typedef union packed {
        logic [`D_CACHE_LINE_W-1:0]                         raw;
        logic [`D_CACHE_WORDS-1:0][`D_CACHE_DATA_W-1:0]     word;
    } t_cl;

    //==================================================================
    // Far memory side
    //==================================================================
    typedef struct packed {
        logic                               valid;
        logic                               write;       // 1 word write, 0 line read
        logic [`D_CACHE_CL_ADRS_W-1:0]      cl_address;
        logic [$clog2(`D_CACHE_WORDS)-1:0]  word_offset; // Writes only
        logic [`D_CACHE_DATA_W-1:0]         data;
    } t_mem_req;

    typedef struct packed {
        logic   valid;
        t_cl    line;
    } t_mem_rsp;

endpackage

`default_nettype wire

// File: design/d_cache_macros.svh
//======================================================================
// Geometry and address field macros for the data cache.
// Included by the package and by every RTL block that sizes a port.
//======================================================================
`ifndef D_CACHE_MACROS_SVH
`define D_CACHE_MACROS_SVH

//======================================================================
// Widths
//======================================================================
`define D_CACHE_ADDR_W      16  // Core byte address
`define D_CACHE_DATA_W      32  // One word
`define D_CACHE_LINE_W      128 // Full cache line
`define D_CACHE_WORDS       4   // Words per line
`define D_CACHE_SET_W       4   // 16 sets
`define D_CACHE_TAG_W       8
`define D_CACHE_CL_ADRS_W   12  // Tag plus set, far memory line index
`define D_CACHE_REG_ID_W    5   // Destination register id

//======================================================================
// Address field positions
//======================================================================
// Bits [1:0] are the byte offset and never decoded
`define D_CACHE_LSB_WORD_OFFSET 2
`define D_CACHE_MSB_WORD_OFFSET 3
`define D_CACHE_LSB_SET         4
`define D_CACHE_MSB_SET         7
`define D_CACHE_LSB_TAG         8
`define D_CACHE_MSB_TAG         15

`endif
